// File: design/audio_pkg.sv
package audio_pkg;

  // ==============================
  // Flash side
  // ==============================
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;

  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Highest word played before the address wraps
  localparam flash_addr_t last_word_addr = 23'h7FFFF;

  // ==============================
  // Sample side
  // ==============================
  typedef logic signed [7:0] sample_t;

  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_beat_t;

  typedef logic [2:0] credit_count_t;

  // Slots in the audio sink
  localparam credit_count_t credit_depth = 3'd4;

  typedef enum logic [1:0] {
    idle,
    request,
    wait_data,
    second_half
  } reader_state_t;

endpackage

// File: design/control_pkg.sv
package control_pkg;

  // ==============================
  // Keyboard
  // ==============================
  typedef logic [7:0] scan_code_t;

  typedef struct packed {
    logic       valid;
    scan_code_t code;
  } kbd_byte_t;

  // Set 2 make codes
  localparam scan_code_t scan_play     = 8'h24;
  localparam scan_code_t scan_pause    = 8'h23;
  localparam scan_code_t scan_forward  = 8'h2B;
  localparam scan_code_t scan_backward = 8'h32;
  localparam scan_code_t scan_restart  = 8'h2D;

  // ==============================
  // Sample period
  // ==============================
  typedef logic [15:0] period_t;

  // About 22 kHz from 50 MHz
  localparam period_t default_period = 16'd2268;
  localparam period_t period_step    = 16'd64;
  localparam period_t min_period     = 16'd512;
  localparam period_t max_period     = 16'd8192;

  // ==============================
  // Seven-segment display
  // ==============================
  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  typedef struct packed {
    seg_t digit5;
    seg_t digit4;
    seg_t digit3;
    seg_t digit2;
    seg_t digit1;
    seg_t digit0;
  } hex_digits_t;

endpackage

// File: design/kbd_command_decoder.sv
`timescale 1ns/1ps

module kbd_command_decoder (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  control_pkg::kbd_byte_t kbd,
  output logic                  play,
  output logic                  forward,
  output logic                  restart
);
  import control_pkg::*;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      play    <= 1'b0;
      forward <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      // Restart only lives for one cycle
      restart <= 1'b0;
      if (kbd.valid)
      begin
        case (kbd.code)
          scan_play:     play    <= 1'b1;
          scan_pause:    play    <= 1'b0;
          scan_forward:  forward <= 1'b1;
          scan_backward: forward <= 1'b0;
          scan_restart:  restart <= 1'b1;
          // Unknown keys are ignored
          default:       restart <= 1'b0;
        endcase
      end
    end
  end

endmodule

// File: design/speed_control.sv
`timescale 1ns/1ps

module speed_control (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  logic                 speed_up,
  input  logic                 speed_down,
  input  logic                 speed_reset,
  output control_pkg::period_t period
);
  import control_pkg::*;

  period_t faster;
  period_t slower;

  // Clamped neighbours of the current period
  always_comb
  begin
    if (period < min_period + period_step)
      faster = min_period;
    else
      faster = period - period_step;

    if (period > max_period - period_step)
      slower = max_period;
    else
      slower = period + period_step;
  end

  // Reset wins over down, down wins over up
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      period <= default_period;
    else if (speed_reset)
      period <= default_period;
    else if (speed_down)
      period <= slower;
    else if (speed_up)
      period <= faster;
  end

endmodule

// File: design/sample_timer.sv
`timescale 1ns/1ps

module sample_timer (
  input  logic                 CLK_50M,
  input  logic                 rst,
  input  control_pkg::period_t period,
  output logic                 tick
);
  import control_pkg::*;

  period_t count;

  // Down-counter, reloads at 1 so a new period only lands on a wrap
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= period;
      tick  <= 1'b0;
    end
    else if (count <= 16'd1)
    begin
      count <= period;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

// File: design/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
  input  logic                    CLK_50M,
  input  logic                    rst,
  input  logic                    tick,
  input  logic                    play,
  input  logic                    forward,
  input  logic                    restart,
  output audio_pkg::flash_req_t   flash_req,
  input  audio_pkg::flash_rsp_t   flash_rsp,
  input  logic                    credit_return,
  output audio_pkg::sample_beat_t sample_out
);
  import audio_pkg::*;

  reader_state_t state;
  flash_addr_t   word_addr;
  flash_addr_t   next_addr;
  logic          read_active;
  logic          restart_pend;
  sample_t       high_sample;
  credit_count_t credits;
  logic          go;
  logic          send_low;
  logic          send_high;

  // A tick only counts while playing and with room in the sink
  assign go = tick && play && (credits != '0);

  // Low half goes out as soon as the word lands, unless a restart came in
  assign send_low  = (state == wait_data) && flash_rsp.readdatavalid
                     && !restart_pend && !restart;
  assign send_high = (state == second_half) && go && !restart;

  assign flash_req = '{read: read_active, address: word_addr};

  // Wrapping step in the current direction
  always_comb
  begin
    if (forward)
      next_addr = (word_addr == last_word_addr) ? '0 : word_addr + 1'b1;
    else
      next_addr = (word_addr == '0) ? last_word_addr : word_addr - 1'b1;
  end

  // ==============================
  // Read FSM and credits
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state            <= idle;
      word_addr        <= '0;
      read_active      <= 1'b0;
      restart_pend     <= 1'b0;
      credits          <= credit_depth;
      sample_out.valid <= 1'b0;
    end
    else
    begin
      // Credit is taken at the send decision
      credits <= credits + credit_count_t'(credit_return)
                 - credit_count_t'(send_low || send_high);
      sample_out.valid <= send_low || send_high;
      // Address must hold while a read is in flight
      if (state == request || state == wait_data)
        restart_pend <= restart_pend | restart;

      case (state)
        idle:
          if (restart)
            word_addr <= '0;
          else if (go)
          begin
            read_active <= 1'b1;
            state       <= request;
          end
        request:
          if (!flash_rsp.waitrequest)
          begin
            read_active <= 1'b0;
            state       <= wait_data;
          end
        wait_data:
          if (send_low)
          begin
            sample_out.data <= flash_rsp.readdata[15:8];
            high_sample     <= flash_rsp.readdata[31:24];
            state           <= second_half;
          end
          else if (flash_rsp.readdatavalid)
          begin
            // Word arrived after a restart, drop it
            word_addr    <= '0;
            restart_pend <= 1'b0;
            state        <= idle;
          end
        second_half:
          if (restart)
          begin
            word_addr <= '0;
            state     <= idle;
          end
          else if (send_high)
          begin
            sample_out.data <= high_sample;
            word_addr       <= next_addr;
            state           <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

// File: design/hex_display.sv
`timescale 1ns/1ps

module hex_display (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::period_t     period,
  output control_pkg::hex_digits_t hex
);
  import control_pkg::*;

  logic [23:0] value_q;

  // Active low hex font, segment a in bit 0
  function automatic seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // Two stages, capture then decode
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      value_q <= '0;
      hex     <= '1;
    end
    else
    begin
      value_q    <= 24'(period);
      hex.digit0 <= seg_decode(value_q[3:0]);
      hex.digit1 <= seg_decode(value_q[7:4]);
      hex.digit2 <= seg_decode(value_q[11:8]);
      hex.digit3 <= seg_decode(value_q[15:12]);
      // Upper byte is always zero
      hex.digit4 <= seg_decode(value_q[19:16]);
      hex.digit5 <= seg_decode(value_q[23:20]);
    end
  end

endmodule

// File: design/ipod_top.sv
`timescale 1ns/1ps

module ipod_top (
  input  logic                     CLK_50M,
  input  logic                     rst,
  input  control_pkg::kbd_byte_t   kbd,
  input  logic                     speed_up,
  input  logic                     speed_down,
  input  logic                     speed_reset,
  output audio_pkg::flash_req_t    flash_req,
  input  audio_pkg::flash_rsp_t    flash_rsp,
  input  logic                     credit_return,
  output audio_pkg::sample_beat_t  sample_out,
  output control_pkg::hex_digits_t hex
);
  import control_pkg::*;

  logic    play;
  logic    forward;
  logic    restart;
  logic    tick;
  period_t period;

  // ==============================
  // Control path
  // ==============================
  kbd_command_decoder i_kbd_command_decoder (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .kbd     (kbd),
    .play    (play),
    .forward (forward),
    .restart (restart)
  );

  speed_control i_speed_control (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .period      (period)
  );

  sample_timer i_sample_timer (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (period),
    .tick    (tick)
  );

  // ==============================
  // Audio path and display
  // ==============================
  flash_reader i_flash_reader (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .tick          (tick),
    .play          (play),
    .forward       (forward),
    .restart       (restart),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .credit_return (credit_return),
    .sample_out    (sample_out)
  );

  hex_display i_hex_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .period  (period),
    .hex     (hex)
  );

endmodule

// File: bench/ipod_checker.sv
`timescale 1ns/1ps

module ipod_checker (
  input logic                    CLK_50M,
  input logic                    rst,
  input audio_pkg::flash_req_t   flash_req,
  input audio_pkg::flash_rsp_t   flash_rsp,
  input logic                    credit_return,
  input audio_pkg::sample_beat_t sample_out
);
  import audio_pkg::*;

  int credits_left;

  // Credits as seen from the sink side
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      credits_left <= int'(credit_depth);
    else
      credits_left <= credits_left + int'(credit_return) - int'(sample_out.valid);
  end

  req_stable: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
    else $error("Flash request changed while waitrequest was high");

  credit_spent: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_out.valid |-> credits_left > 0)
    else $error("Sample sent with no credit left");

  reset_quiet: assert property (@(posedge CLK_50M)
    rst |=> !flash_req.read && !sample_out.valid)
    else $error("Flash read or sample valid active during reset");

endmodule

bind ipod_top ipod_checker i_ipod_checker (.*);

// File: bench/ipod_tb.sv
`timescale 1ns/1ps

module ipod_tb;
  import audio_pkg::*;
  import control_pkg::*;

  // Covers about 50 samples at up to two default periods each plus the pauses
  localparam int timeout_cycles = 400000;

  logic         CLK_50M;
  logic         rst;
  kbd_byte_t    kbd;
  logic         speed_up;
  logic         speed_down;
  logic         speed_reset;
  flash_req_t   flash_req;
  flash_rsp_t   flash_rsp;
  logic         credit_return;
  sample_beat_t sample_out;
  hex_digits_t  hex;

  logic [15:0]  lfsr;
  int           cycles;
  // Flash model state
  logic         in_req;
  int           wait_left;
  int           lat_left;
  flash_addr_t  pend_addr;
  // Sink state
  int           fill;
  int           drain_wait;
  logic         slow_drain;
  int           full_cycles;
  // Reference state
  flash_addr_t  exp_addr;
  logic         exp_high;
  logic         exp_fwd;
  period_t      exp_period;
  int           samples_seen;
  int           paused_count;

  ipod_top i_ipod_top (.*);

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Reference functions
  // ==============================
  function automatic flash_word_t flash_word(input flash_addr_t addr);
    return {9'd0, addr} * 32'h9E3779B1;
  endfunction

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] expected_sample(input flash_addr_t addr, input logic high);
    flash_word_t w;
    w = flash_word(addr);
    return high ? w[31:24] : w[15:8];
  endfunction

  function automatic flash_addr_t step_addr(input flash_addr_t addr, input logic fwd);
    if (fwd)
      return (addr == last_word_addr) ? '0 : addr + 23'd1;
    return (addr == '0) ? last_word_addr : addr - 23'd1;
  endfunction

  // Reset first, then down, then up, then the limits
  function automatic period_t next_period(input period_t p, input logic up, input logic down,
                                          input logic reset);
    int v;
    if (reset)
      return default_period;
    v = int'(p);
    if (down)
      v = v + int'(period_step);
    else if (up)
      v = v - int'(period_step);
    if (v < int'(min_period))
      v = int'(min_period);
    if (v > int'(max_period))
      v = int'(max_period);
    return period_t'(v);
  endfunction

  // Lit segments in gfedcba order
  function automatic logic [6:0] seg_font(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h3F;
      4'h1: return 7'h06;
      4'h2: return 7'h5B;
      4'h3: return 7'h4F;
      4'h4: return 7'h66;
      4'h5: return 7'h6D;
      4'h6: return 7'h7D;
      4'h7: return 7'h07;
      4'h8: return 7'h7F;
      4'h9: return 7'h6F;
      4'hA: return 7'h77;
      4'hB: return 7'h7C;
      4'hC: return 7'h39;
      4'hD: return 7'h5E;
      4'hE: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  function automatic hex_digits_t expected_hex(input period_t p);
    hex_digits_t h;
    h.digit0 = ~seg_font(p[3:0]);
    h.digit1 = ~seg_font(p[7:4]);
    h.digit2 = ~seg_font(p[11:8]);
    h.digit3 = ~seg_font(p[15:12]);
    h.digit4 = ~seg_font(4'h0);
    h.digit5 = ~seg_font(4'h0);
    return h;
  endfunction

  // ==============================
  // Helper tasks
  // ==============================
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
  endtask

  task automatic wait_samples(input int target);
    while (samples_seen < target)
      @(posedge CLK_50M);
  endtask

  task automatic press_key(input scan_code_t code);
    @(posedge CLK_50M);
    #1;
    kbd = '{valid: 1'b1, code: code};
    @(posedge CLK_50M);
    #1;
    kbd = '{valid: 1'b0, code: 8'h00};
  endtask

  task automatic check_hex();
    #1;
    assert (hex == expected_hex(exp_period))
    else report_failure($sformatf("Mismatch at %0t: hex %h expected %h for period %0d",
                                  $time, hex, expected_hex(exp_period), exp_period));
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic reset);
    @(posedge CLK_50M);
    #1;
    speed_up    = up;
    speed_down  = down;
    speed_reset = reset;
    exp_period  = next_period(exp_period, up, down, reset);
    @(posedge CLK_50M);
    #1;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    wait_cycles(4);
    check_hex();
  endtask

  // Pause and let any read in flight finish
  task automatic pause_and_settle();
    press_key(scan_pause);
    wait_cycles(20);
  endtask

  // ==============================
  // Flash model and audio sink
  // ==============================
  always @(posedge CLK_50M)
  begin
    int pick;
    int delay;
    #1;
    flash_rsp.readdatavalid = 1'b0;
    flash_rsp.waitrequest   = 1'b0;
    if (lat_left > 0)
    begin
      lat_left--;
      if (lat_left == 0)
      begin
        flash_rsp.readdatavalid = 1'b1;
        flash_rsp.readdata      = flash_word(pend_addr);
      end
    end
    if (!rst && flash_req.read)
    begin
      if (!in_req)
      begin
        in_req = 1'b1;
        take_bits(2, pick);
        wait_left = pick;
      end
      if (wait_left > 0)
      begin
        flash_rsp.waitrequest = 1'b1;
        wait_left--;
      end
      else
      begin
        // Accepted in this cycle
        in_req    = 1'b0;
        pend_addr = flash_req.address;
        take_bits(2, pick);
        lat_left  = 1 + pick % 3;
      end
    end

    // Audio sink
    credit_return = 1'b0;
    if (rst)
    begin
      fill       = 0;
      drain_wait = 0;
    end
    else
    begin
      if (sample_out.valid)
        fill++;
      assert (fill <= int'(credit_depth))
      else report_failure("Sink overflow, a sample arrived with no free slot");
      if (fill == int'(credit_depth))
        full_cycles++;
      if (fill > 0)
      begin
        if (drain_wait == 0)
        begin
          credit_return = 1'b1;
          fill--;
          take_bits(slow_drain ? 8 : 3, delay);
          // Slow drain takes longer than a sample period
          drain_wait = slow_drain ? 2 * int'(default_period) + delay : delay;
        end
        else
          drain_wait--;
      end
    end
  end

  // Sample compare against the reference
  always @(negedge CLK_50M)
  begin
    if (!rst && sample_out.valid)
    begin
      assert (sample_out.data == expected_sample(exp_addr, exp_high))
      else report_failure($sformatf("Mismatch at %0t: sample %0d addr %h got %h expected %h",
                                    $time, samples_seen, exp_addr, sample_out.data,
                                    expected_sample(exp_addr, exp_high)));
      if (exp_high)
        exp_addr = step_addr(exp_addr, exp_fwd);
      exp_high = !exp_high;
      samples_seen++;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (cycles >= timeout_cycles)
      report_failure("Run timed out before all tests finished");
  end

  // ==============================
  // Stimulus
  // ==============================
  initial
  begin
    rst           = 1'b1;
    kbd           = '{valid: 1'b0, code: 8'h00};
    speed_up      = 1'b0;
    speed_down    = 1'b0;
    speed_reset   = 1'b0;
    flash_rsp     = '0;
    credit_return = 1'b0;
    lfsr          = 16'd20;
    cycles        = 0;
    in_req        = 1'b0;
    wait_left     = 0;
    lat_left      = 0;
    pend_addr     = '0;
    fill          = 0;
    drain_wait    = 0;
    slow_drain    = 1'b0;
    full_cycles   = 0;
    exp_addr      = '0;
    exp_high      = 1'b0;
    exp_fwd       = 1'b1;
    exp_period    = default_period;
    samples_seen  = 0;
    repeat (16) @(posedge CLK_50M);
    #1;
    rst = 1'b0;
    wait_cycles(4);
    check_hex();

    // Forward play from address 0
    press_key(scan_play);
    wait_samples(24);

    // Pause holds the stream
    pause_and_settle();
    paused_count = samples_seen;
    wait_cycles(3 * int'(default_period));
    assert (samples_seen == paused_count)
    else report_failure("Samples kept coming after the pause key");

    // Slow sink forces stalls
    slow_drain = 1'b1;
    press_key(scan_play);
    wait_samples(samples_seen + 12);
    slow_drain = 1'b0;

    // Backward from a restart wraps below 0
    pause_and_settle();
    press_key(scan_restart);
    exp_addr = '0;
    exp_high = 1'b0;
    press_key(scan_backward);
    exp_fwd = 1'b0;
    press_key(scan_play);
    wait_samples(samples_seen + 8);

    pause_and_settle();
    press_key(scan_restart);
    exp_addr = '0;
    exp_high = 1'b0;
    press_key(scan_forward);
    exp_fwd = 1'b1;
    press_key(scan_play);
    wait_samples(samples_seen + 6);
    pause_and_settle();

    // Speed events and priority
    pulse_speed(1'b0, 1'b1, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b1, 1'b0, 1'b0);
    pulse_speed(1'b0, 1'b0, 1'b1);
    pulse_speed(1'b1, 1'b1, 1'b0);
    pulse_speed(1'b0, 1'b1, 1'b1);

    // Clamp at both limits
    repeat (32) pulse_speed(1'b1, 1'b0, 1'b0);
    repeat (124) pulse_speed(1'b0, 1'b1, 1'b0);

    if (full_cycles > 0)
    begin
      $display("test passed");
      $finish;
    end
    else
      report_failure("The slow sink never filled up, back-pressure was not exercised");
  end

endmodule

// File: src.f
design/audio_pkg.sv
design/control_pkg.sv
design/kbd_command_decoder.sv
design/speed_control.sv
design/sample_timer.sv
design/flash_reader.sv
design/hex_display.sv
design/ipod_top.sv
bench/ipod_checker.sv
bench/ipod_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ipod testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ipod_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vipod_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
echo "Simulation finished"
